//--- design/multicore_cfg.svh
`ifndef MULTICORE_CFG_SVH
`define MULTICORE_CFG_SVH

// Number of identical MAC cores on the broadcast sample bus.
`define NUM_CORES 4

// Cycles between two core releases from reset.
`define RESET_GAP 6

// Accepted samples per posted result.
// Keep this at or above the core count so every pending result drains in time.
`define SAMPLES_PER_RESULT 8

// Core i gets weight WEIGHT_BASE plus i times WEIGHT_STEP.
`define WEIGHT_BASE 3
`define WEIGHT_STEP 2

`endif

//--- design/multicore_pkg.sv
`include "multicore_cfg.svh"

package multicore_pkg;

	// Fixed-point sample on the broadcast bus.
	typedef logic signed [18:0] sample_t;

	// Per-core weight.
	typedef logic signed [7:0] weight_t;

	// Room for a full group of products without overflow.
	typedef logic signed [27:0] result_t;

	typedef logic [1:0] core_id_t;

	// One bit per core.
	typedef logic [`NUM_CORES-1:0] core_mask_t;

	// A finished result tagged with the core that made it.
	typedef struct packed {
		core_id_t core;
		result_t value;
	} result_msg_t;

	typedef enum logic [1:0] {
		core_held,
		core_accumulating,
		core_pending
	} core_state_t;

	typedef enum logic {
		seq_counting,
		seq_done
	} seq_state_t;

endpackage

//--- design/reset_sequencer.sv
`include "multicore_cfg.svh"

module reset_sequencer (
	input logic clk,
	input logic reset,
	output multicore_pkg::core_mask_t run_mask
);

	localparam int gap_w = $clog2(`RESET_GAP + 1);
	localparam logic [gap_w-1:0] gap_end = gap_w'(`RESET_GAP);
	localparam multicore_pkg::core_id_t last_core = multicore_pkg::core_id_t'(`NUM_CORES - 1);

	multicore_pkg::seq_state_t state;
	multicore_pkg::core_id_t next_core;
	logic [gap_w-1:0] gap_cnt;

	// The counter starts at one in the first cycle after reset, so a core
	// is released on the edge that ends every RESET_GAP-th cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= multicore_pkg::seq_counting;
			gap_cnt <= gap_w'(1);
			next_core <= '0;
			run_mask <= '0;
		end else begin
			case (state)
				multicore_pkg::seq_counting: begin
					if (gap_cnt == gap_end) begin
						run_mask[next_core] <= 1'b1;
						gap_cnt <= gap_w'(1);
						if (next_core == last_core) begin
							state <= multicore_pkg::seq_done; // All cores are running.
						end else begin
							next_core <= next_core + 1'b1;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				multicore_pkg::seq_done: begin
					state <= multicore_pkg::seq_done; // Only a global reset leaves here.
				end
				default: begin
					state <= multicore_pkg::seq_counting;
				end
			endcase
		end
	end

endmodule

//--- design/mac_core.sv
`include "multicore_cfg.svh"

module mac_core #(
	parameter multicore_pkg::weight_t weight = 8'sd1
) (
	input logic clk,
	input logic reset,
	input logic run,
	input multicore_pkg::sample_t sample,
	input logic sample_valid,
	input logic grant,
	output logic req,
	output multicore_pkg::result_t result
);

	localparam int cnt_w = $clog2(`SAMPLES_PER_RESULT);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`SAMPLES_PER_RESULT - 1);

	multicore_pkg::core_state_t state;
	multicore_pkg::core_state_t state_next;
	multicore_pkg::result_t acc;
	multicore_pkg::result_t product;
	multicore_pkg::result_t acc_next;
	multicore_pkg::result_t result_q;
	logic [cnt_w-1:0] sample_cnt;
	logic accept;
	logic group_done;

	// Both operands are signed, so the product is sign extended to the
	// accumulator width before the add.
	assign product = sample * weight;
	assign acc_next = acc + product;

	// Run is a registered level, so a high value here means the core was
	// already released when this cycle began.
	assign accept = run && sample_valid;
	assign group_done = accept && (sample_cnt == last_cnt);

	always_comb begin
		state_next = state;
		case (state)
			multicore_pkg::core_held: begin
				if (run) begin
					state_next = multicore_pkg::core_accumulating;
				end
			end
			multicore_pkg::core_accumulating: begin
				if (group_done) begin
					state_next = multicore_pkg::core_pending;
				end
			end
			multicore_pkg::core_pending: begin
				// A fresh completion keeps the core pending with the new sum.
				if (grant && !group_done) begin
					state_next = multicore_pkg::core_accumulating;
				end
			end
			default: begin
				state_next = multicore_pkg::core_held;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= multicore_pkg::core_held;
			acc <= '0;
			sample_cnt <= '0;
		end else begin
			state <= state_next;
			if (group_done) begin
				acc <= '0;
				sample_cnt <= '0;
			end else if (accept) begin
				acc <= acc_next;
				sample_cnt <= sample_cnt + 1'b1;
			end
		end
	end

	// The finished sum waits here until the arbiter takes it.
	always_ff @(posedge clk) begin
		if (group_done) begin
			result_q <= acc_next;
		end
	end

	assign req = (state == multicore_pkg::core_pending);
	assign result = result_q;

endmodule

//--- design/result_arbiter.sv
`include "multicore_cfg.svh"

module result_arbiter (
	input logic clk,
	input logic reset,
	input multicore_pkg::core_mask_t req_mask,
	input multicore_pkg::result_t results [`NUM_CORES],
	output multicore_pkg::core_mask_t grant_mask,
	output multicore_pkg::result_msg_t out_msg,
	output logic out_valid
);

	multicore_pkg::core_id_t sel;
	logic any_req;

	assign any_req = |req_mask;

	// Scan from the top index down so the lowest requesting core is the last
	// one written and wins.
	always_comb begin
		grant_mask = '0;
		sel = '0;
		for (int i = `NUM_CORES - 1; i >= 0; i--) begin
			if (req_mask[i]) begin
				grant_mask = multicore_pkg::core_mask_t'(1) << i;
				sel = multicore_pkg::core_id_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= any_req; // One beat per granted result.
		end
	end

	always_ff @(posedge clk) begin
		if (any_req) begin
			out_msg.core <= sel;
			out_msg.value <= results[sel];
		end
	end

endmodule

//--- design/multicore_top.sv
`include "multicore_cfg.svh"

module multicore_top (
	input logic clk,
	input logic reset,
	input multicore_pkg::sample_t sample,
	input logic sample_valid,
	output multicore_pkg::core_mask_t run_mask,
	output multicore_pkg::result_msg_t out_msg,
	output logic out_valid
);

	multicore_pkg::core_mask_t req_mask;
	multicore_pkg::core_mask_t grant_mask;
	multicore_pkg::result_t results [`NUM_CORES];

	reset_sequencer sequencer_i (
		.clk(clk),
		.reset(reset),
		.run_mask(run_mask)
	);

	// Every core sees the same sample bus and differs only in its weight.
	for (genvar i = 0; i < `NUM_CORES; i++) begin : g_core
		mac_core #(
			.weight(multicore_pkg::weight_t'(`WEIGHT_BASE + i * `WEIGHT_STEP))
		) core_i (
			.clk(clk),
			.reset(reset),
			.run(run_mask[i]),
			.sample(sample),
			.sample_valid(sample_valid),
			.grant(grant_mask[i]),
			.req(req_mask[i]),
			.result(results[i])
		);
	end

	result_arbiter arbiter_i (
		.clk(clk),
		.reset(reset),
		.req_mask(req_mask),
		.results(results),
		.grant_mask(grant_mask),
		.out_msg(out_msg),
		.out_valid(out_valid)
	);

endmodule

//--- verification/multicore_checks.sv
`include "multicore_cfg.svh"

module multicore_checks (
	input logic clk,
	input logic reset,
	input multicore_pkg::core_mask_t run_mask,
	input multicore_pkg::core_mask_t exp_run_mask,
	input logic out_valid,
	input multicore_pkg::result_msg_t out_msg,
	input logic exp_valid,
	input multicore_pkg::result_msg_t exp_msg,
	output int error_count
);
	timeunit 1ns;
	timeprecision 1ps;

	multicore_pkg::core_mask_t prev_mask = '0;
	logic reset_seen = 1'b1;

	initial begin
		error_count = 0;
	end

	// A reset seen on this edge allows run_mask bits to fall.
	always @(posedge clk) begin
		reset_seen = reset;
	end

	// All DUT outputs are registered, so the middle of the cycle is a stable point.
	always @(negedge clk) begin
		multicore_pkg::core_mask_t above;
		above = run_mask + 1'b1;
		assert (run_mask === exp_run_mask) else begin
			error_count++;
			$display("[ERROR] %0d ns: run_mask is %b, expected %b",
				$time, run_mask, exp_run_mask);
		end
		// Released cores always form a run of ones from core 0 up.
		assert ((run_mask & above) == '0) else begin
			error_count++;
			$display("[ERROR] %0d ns: run_mask %b released cores out of order",
				$time, run_mask);
		end
		if (!reset_seen) begin
			assert ((run_mask & prev_mask) == prev_mask) else begin
				error_count++;
				$display("[ERROR] %0d ns: run_mask fell from %b to %b without reset",
					$time, prev_mask, run_mask);
			end
		end
		prev_mask = run_mask;
		assert (out_valid === exp_valid) else begin
			error_count++;
			$display("[ERROR] %0d ns: out_valid is %b, expected %b",
				$time, out_valid, exp_valid);
		end
		if (out_valid && exp_valid) begin
			assert (out_msg.core === exp_msg.core) else begin
				error_count++;
				$display("[ERROR] %0d ns: result came from core %0d, expected core %0d",
					$time, out_msg.core, exp_msg.core);
			end
			assert (out_msg.value === exp_msg.value) else begin
				error_count++;
				$display("[ERROR] %0d ns: core %0d result is %0d, expected %0d",
					$time, exp_msg.core, out_msg.value, exp_msg.value);
			end
		end
	end

endmodule

//--- verification/multicore_tb.sv
`include "multicore_cfg.svh"

module multicore_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int total_samples = 60 + 64 + 32 + 48 + 24 + 40;
	localparam int release_cycles = 16 + `NUM_CORES * `RESET_GAP;
	// Sparse samples take at most four cycles each.
	localparam int cycle_limit = total_samples * 4 + 5 * release_cycles + 200;
	localparam multicore_pkg::core_mask_t all_running = '1;

	logic clk = 1'b0;
	logic reset;
	multicore_pkg::sample_t sample;
	logic sample_valid;
	multicore_pkg::core_mask_t run_mask;
	multicore_pkg::result_msg_t out_msg;
	logic out_valid;

	multicore_pkg::core_mask_t exp_run_mask = '0;
	logic exp_valid = 1'b0;
	multicore_pkg::result_msg_t exp_msg = '0;
	multicore_pkg::core_mask_t pend_valid = '0;
	multicore_pkg::result_t pend_value [`NUM_CORES];
	int acc [`NUM_CORES];
	int cnt [`NUM_CORES];
	int since_reset = 0;
	int beat_count = 0;
	int burst_len = 0;
	int max_burst = 0;

	int check_errors;
	int tb_errors = 0;
	int cycle_count = 0;
	int test_num = 0;
	int errors_at_start = 0;
	int beats_at_start = 0;
	logic [31:0] lfsr_state = 32'hedc7;

	multicore_top dut_i (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sample_valid(sample_valid),
		.run_mask(run_mask),
		.out_msg(out_msg),
		.out_valid(out_valid)
	);

	multicore_checks checks_i (
		.clk(clk),
		.reset(reset),
		.run_mask(run_mask),
		.exp_run_mask(exp_run_mask),
		.out_valid(out_valid),
		.out_msg(out_msg),
		.exp_valid(exp_valid),
		.exp_msg(exp_msg),
		.error_count(check_errors)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("Errors found");
			$finish;
		end
	end

	function automatic int weight_of(input int core);
		return `WEIGHT_BASE + core * `WEIGHT_STEP;
	endfunction

	// Reference model. Values read here are the ones held during the cycle that just ended.
	always @(posedge clk) begin
		bit found;
		if (reset) begin
			since_reset = 0;
			exp_run_mask = '0;
			exp_valid = 1'b0;
			pend_valid = '0;
			burst_len = 0;
			for (int i = 0; i < `NUM_CORES; i++) begin
				acc[i] = 0;
				cnt[i] = 0;
			end
		end else begin
			// The lowest pending core owns the output bus in the next cycle.
			found = 1'b0;
			exp_valid = 1'b0;
			for (int i = 0; i < `NUM_CORES; i++) begin
				if (pend_valid[i] && !found) begin
					found = 1'b1;
					exp_valid = 1'b1;
					exp_msg.core = multicore_pkg::core_id_t'(i);
					exp_msg.value = pend_value[i];
					pend_valid[i] = 1'b0;
				end
			end
			// Beats and back-to-back runs of beats as the DUT drove them.
			if (out_valid) begin
				beat_count++;
				burst_len++;
			end else begin
				burst_len = 0;
			end
			if (burst_len > max_burst) begin
				max_burst = burst_len;
			end
			for (int i = 0; i < `NUM_CORES; i++) begin
				if (run_mask[i] && sample_valid) begin
					acc[i] = acc[i] + int'(sample) * weight_of(i);
					cnt[i]++;
					if (cnt[i] == `SAMPLES_PER_RESULT) begin
						pend_valid[i] = 1'b1;
						pend_value[i] = multicore_pkg::result_t'(acc[i]);
						acc[i] = 0;
						cnt[i] = 0;
					end
				end
			end
			since_reset++;
			for (int i = 0; i < `NUM_CORES; i++) begin
				exp_run_mask[i] = (since_reset >= (i + 1) * `RESET_GAP);
			end
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	// Called on a falling edge; reset rises right away.
	task automatic apply_reset();
		reset = 1'b1;
		sample_valid = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic wait_release();
		while (run_mask !== all_running) @(negedge clk);
	endtask

	task automatic wait_idle();
		while (pend_valid != '0 || exp_valid) @(negedge clk);
	endtask

	task automatic send_samples(input int count, input bit sparse);
		logic [31:0] bits;
		logic [31:0] pick;
		logic [31:0] gap;
		multicore_pkg::sample_t value;
		for (int n = 0; n < count; n++) begin
			take_bits(19, bits);
			value = multicore_pkg::sample_t'(bits[18:0]);
			if (sparse) begin
				take_bits(2, pick);
				case (pick[1:0])
					2'd0: value = {1'b0, {18{1'b1}}}; // Largest positive sample.
					2'd1: value = {1'b1, 18'b0}; // Most negative sample.
					2'd2: value = '1;
					default: value = value;
				endcase
			end
			@(negedge clk);
			sample = value;
			sample_valid = 1'b1;
			if (sparse) begin
				take_bits(2, gap);
				for (int g = 0; g < gap; g++) begin
					@(negedge clk);
					sample_valid = 1'b0;
				end
			end
		end
		@(negedge clk);
		sample_valid = 1'b0;
	endtask

	task automatic begin_test();
		test_num++;
		errors_at_start = check_errors + tb_errors;
		beats_at_start = beat_count;
		max_burst = 0;
	endtask

	task automatic end_test(input string name, input bit want_results, input bit want_burst);
		int test_errors;
		wait_idle();
		if (want_results) begin
			assert (beat_count > beats_at_start) else begin
				tb_errors++;
				$display("Test %0d sent samples but no result came out.", test_num);
			end
		end
		if (want_burst) begin
			assert (max_burst >= `NUM_CORES) else begin
				tb_errors++;
				$display("Test %0d never sent results from all cores on back-to-back cycles.",
					test_num);
			end
		end
		test_errors = check_errors + tb_errors - errors_at_start;
		$display("Test %0d %s: %0d errors", test_num, name, test_errors);
	endtask

	initial begin
		reset = 1'b1;
		sample = '0;
		sample_valid = 1'b0;

		begin_test();
		apply_reset();
		wait_release();
		end_test("staggered release", 1'b0, 1'b0);

		// Samples start right after reset, so later cores miss the first ones.
		begin_test();
		apply_reset();
		send_samples(60, 1'b0);
		end_test("samples during release", 1'b1, 1'b0);

		begin_test();
		send_samples(64, 1'b0);
		end_test("steady accumulation", 1'b1, 1'b0);

		// With no samples during release every core completes on the same edges.
		begin_test();
		apply_reset();
		wait_release();
		send_samples(32, 1'b0);
		end_test("priority order", 1'b1, 1'b1);

		begin_test();
		send_samples(48, 1'b1);
		end_test("sparse samples", 1'b1, 1'b0);

		begin_test();
		send_samples(24, 1'b0);
		apply_reset(); // Lands while the last group is still pending.
		wait_release();
		send_samples(40, 1'b0);
		end_test("reset mid-run", 1'b1, 1'b0);

		$display("Tests run: %0d, errors: %0d", test_num, check_errors + tb_errors);
		if (check_errors + tb_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+design
design/multicore_pkg.sv
design/reset_sequencer.sv
design/mac_core.sv
design/result_arbiter.sv
design/multicore_top.sv
verification/multicore_checks.sv
verification/multicore_tb.sv
